//--- flist.f
hdl/rv_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/cache_if.sv
hdl/regfile.sv
hdl/hazard_control.sv
hdl/mul_stage.sv
hdl/datapath.sv
hdl/mem_model.sv
hdl/core_top.sv
tb/core_checker.sv
tb/tb_core.sv

//--- hdl/cache_if.sv
interface cache_if;
	logic access;
	logic write;
	logic [31:0] addr;
	logic [31:0] wr_data;
	logic [31:0] rd_data;
	logic hit;

	modport master (
		output access, write, addr, wr_data,
		input rd_data, hit
	);

	modport slave (
		input access, write, addr, wr_data,
		output rd_data, hit
	);
endinterface

//--- hdl/core_pipe_pkg.sv
package core_pipe_pkg;
	localparam logic [31:0] RESET_PC = 32'h0000_1000;

	typedef enum logic {
		ALU_ADD,
		ALU_SUB
	} alu_op_e;

	typedef enum logic {
		WB_ALU,
		WB_LOAD
	} wb_sel_e;

	typedef struct packed {
		logic valid;
		rv_isa_pkg::rv_instr_u instr;
	} pipe_id_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [31:0] op1;
		logic [31:0] op2; // Also the store data.
		logic [31:0] imm;
		logic regfile_we;
		logic mem_read;
		logic mem_write;
		logic is_ecall;
		logic use_imm;
		alu_op_e alu_op;
		wb_sel_e wb_sel;
	} pipe_ex_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [31:0] alu_out;
		logic [31:0] store_data;
		logic regfile_we;
		logic mem_read;
		logic mem_write;
		logic is_ecall;
		wb_sel_e wb_sel;
	} pipe_mem_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [31:0] result;
		logic [31:0] load_data;
		logic regfile_we;
		logic is_ecall;
		wb_sel_e wb_sel;
	} pipe_wb_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] product;
	} mul_slot_t;
endpackage

//--- hdl/core_top.sv
module core_top #(
	parameter int MUL_STAGES = 4,
	parameter int MEM_WORDS = 2048
) (
	input logic clk_i,
	input logic reset_i,
	input logic prog_we_i,
	input logic [10:0] prog_addr_i,
	input logic [31:0] prog_data_i,
	input logic [4:0] dbg_addr_i,
	output logic [31:0] dbg_data_o,
	output logic halted_o,
	output logic [31:0] retired_o
);
	cache_if ibus ();
	cache_if dbus ();

	datapath #(
		.MUL_STAGES(MUL_STAGES)
	) datapath_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.dbg_addr_i(dbg_addr_i),
		.icache_bus(ibus.master),
		.dcache_bus(dbus.master),
		.dbg_data_o(dbg_data_o),
		.halted_o(halted_o),
		.retired_o(retired_o)
	);

	mem_model #(
		.MEM_WORDS(MEM_WORDS)
	) mem_model_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ibus(ibus.slave),
		.dbus(dbus.slave),
		.prog_we_i(prog_we_i),
		.prog_addr_i(prog_addr_i),
		.prog_data_i(prog_data_i)
	);
endmodule

//--- hdl/datapath.sv
module datapath #(
	parameter int MUL_STAGES = 4
) (
	input logic clk_i,
	input logic reset_i,
	input logic [4:0] dbg_addr_i,
	cache_if.master icache_bus,
	cache_if.master dcache_bus,
	output logic [31:0] dbg_data_o,
	output logic halted_o,
	output logic [31:0] retired_o
);
	logic [31:0] pc;
	core_pipe_pkg::pipe_id_t id_reg;
	core_pipe_pkg::pipe_id_t next_id;
	core_pipe_pkg::pipe_ex_t decode;
	core_pipe_pkg::pipe_ex_t ex_reg;
	core_pipe_pkg::pipe_ex_t next_ex;
	core_pipe_pkg::pipe_mem_t mem_reg;
	core_pipe_pkg::pipe_mem_t next_mem;
	core_pipe_pkg::pipe_wb_t wb_reg;
	core_pipe_pkg::pipe_wb_t next_wb;
	core_pipe_pkg::mul_slot_t mul_chain [MUL_STAGES+1];
	logic [MUL_STAGES-1:0] mul_busy;
	logic [MUL_STAGES-1:0][4:0] mul_rd;
	logic pc_stall;
	logic id_stall;
	logic ex_stall;
	logic mem_stall;
	logic ex_valid;
	logic mul_issue;
	logic halt;
	logic halt_seen;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] imm;
	logic [31:0] alu_b;
	logic [31:0] alu_out;
	logic [31:0] wb_data;

	hazard_control #(
		.MUL_STAGES(MUL_STAGES)
	) hazard_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.id_reg_i(id_reg),
		.ex_reg_i(ex_reg),
		.mem_reg_i(mem_reg),
		.wb_reg_i(wb_reg),
		.mul_busy_i(mul_busy),
		.mul_rd_i(mul_rd),
		.icache_hit_i(icache_bus.hit),
		.dcache_hit_i(dcache_bus.hit),
		.decode_o(decode),
		.pc_stall_o(pc_stall),
		.id_stall_o(id_stall),
		.ex_stall_o(ex_stall),
		.mem_stall_o(mem_stall),
		.ex_valid_o(ex_valid),
		.mul_issue_o(mul_issue),
		.icache_access_o(icache_bus.access),
		.halt_o(halt)
	);

	always_ff @(posedge clk_i) begin
		if (reset_i)
			pc <= core_pipe_pkg::RESET_PC;
		else if (!pc_stall)
			pc <= pc + 32'd4;
	end

	assign icache_bus.addr = pc;
	assign icache_bus.write = 1'b0;
	assign icache_bus.wr_data = '0;
	assign next_id.valid = icache_bus.hit && !halt;
	assign next_id.instr = icache_bus.rd_data;

	always_ff @(posedge clk_i) begin
		if (reset_i)
			id_reg.valid <= 1'b0;
		else if (!id_stall)
			id_reg <= next_id;
	end

	regfile regfile_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rd_addr1_i(id_reg.instr.rtype.rs1),
		.rd_addr2_i(id_reg.instr.rtype.rs2),
		.dbg_addr_i(dbg_addr_i),
		.wr_addr_i(wb_reg.rd),
		.wr_data_i(wb_data),
		.wr_en_i(wb_reg.valid && wb_reg.regfile_we),
		.mul_wr_addr_i(mul_chain[MUL_STAGES].rd),
		.mul_wr_data_i(mul_chain[MUL_STAGES].product),
		.mul_wr_en_i(mul_chain[MUL_STAGES].valid),
		.rd_data1_o(rs1_data),
		.rd_data2_o(rs2_data),
		.dbg_data_o(dbg_data_o)
	);

	always_comb begin
		if (decode.mem_write)
			imm = {{20{id_reg.instr.stype.imm_hi[6]}}, id_reg.instr.stype.imm_hi,
				id_reg.instr.stype.imm_lo};
		else
			imm = {{20{id_reg.instr.itype.imm[11]}}, id_reg.instr.itype.imm};
		next_ex = decode;
		next_ex.valid = ex_valid;
		next_ex.op1 = rs1_data;
		next_ex.op2 = rs2_data;
		next_ex.imm = imm;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			ex_reg.valid <= 1'b0;
		else if (!ex_stall)
			ex_reg <= next_ex;
	end

	assign alu_b = ex_reg.use_imm ? ex_reg.imm : ex_reg.op2;
	assign alu_out = (ex_reg.alu_op == core_pipe_pkg::ALU_SUB) ?
		ex_reg.op1 - alu_b : ex_reg.op1 + alu_b;

	always_comb begin
		next_mem.valid = ex_reg.valid;
		next_mem.rd = ex_reg.rd;
		next_mem.alu_out = alu_out;
		next_mem.store_data = ex_reg.op2;
		next_mem.regfile_we = ex_reg.regfile_we;
		next_mem.mem_read = ex_reg.mem_read;
		next_mem.mem_write = ex_reg.mem_write;
		next_mem.is_ecall = ex_reg.is_ecall;
		next_mem.wb_sel = ex_reg.wb_sel;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			mem_reg.valid <= 1'b0;
		else if (!mem_stall)
			mem_reg <= next_mem;
	end

	assign dcache_bus.access = mem_reg.valid && (mem_reg.mem_read || mem_reg.mem_write);
	assign dcache_bus.write = mem_reg.mem_write;
	assign dcache_bus.addr = mem_reg.alu_out;
	assign dcache_bus.wr_data = mem_reg.store_data;

	always_comb begin
		next_wb.valid = mem_reg.valid && !mem_stall; // Bubble while waiting for hit.
		next_wb.rd = mem_reg.rd;
		next_wb.result = mem_reg.alu_out;
		next_wb.load_data = dcache_bus.rd_data;
		next_wb.regfile_we = mem_reg.regfile_we;
		next_wb.is_ecall = mem_reg.is_ecall;
		next_wb.wb_sel = mem_reg.wb_sel;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			wb_reg.valid <= 1'b0;
		else
			wb_reg <= next_wb;
	end

	assign wb_data = (wb_reg.wb_sel == core_pipe_pkg::WB_LOAD) ? wb_reg.load_data : wb_reg.result;

	assign mul_chain[0] = '{valid: mul_issue, rd: id_reg.instr.rtype.rd,
		op1: rs1_data, op2: rs2_data, product: 32'd0};

	for (genvar i = 0; i < MUL_STAGES; i++) begin : g_mul
		mul_stage #(
			.LAST(i == MUL_STAGES - 1)
		) mul_stage_i (
			.clk_i(clk_i),
			.reset_i(reset_i),
			.slot_i(mul_chain[i]),
			.slot_o(mul_chain[i + 1])
		);
		assign mul_busy[i] = mul_chain[i + 1].valid;
		assign mul_rd[i] = mul_chain[i + 1].rd;
	end

	assign halted_o = halt_seen || (wb_reg.valid && wb_reg.is_ecall);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			halt_seen <= 1'b0;
			retired_o <= '0;
		end else begin
			halt_seen <= halted_o;
			// Both write ports can retire in the same cycle.
			retired_o <= retired_o + {31'd0, wb_reg.valid} +
				{31'd0, mul_chain[MUL_STAGES].valid};
		end
	end
endmodule

//--- hdl/hazard_control.sv
module hazard_control #(
	parameter int MUL_STAGES = 4
) (
	input logic clk_i,
	input logic reset_i,
	input core_pipe_pkg::pipe_id_t id_reg_i,
	input core_pipe_pkg::pipe_ex_t ex_reg_i,
	input core_pipe_pkg::pipe_mem_t mem_reg_i,
	input core_pipe_pkg::pipe_wb_t wb_reg_i,
	input logic [MUL_STAGES-1:0] mul_busy_i,
	input logic [MUL_STAGES-1:0][4:0] mul_rd_i,
	input logic icache_hit_i,
	input logic dcache_hit_i,
	output core_pipe_pkg::pipe_ex_t decode_o,
	output logic pc_stall_o,
	output logic id_stall_o,
	output logic ex_stall_o,
	output logic mem_stall_o,
	output logic ex_valid_o,
	output logic mul_issue_o,
	output logic icache_access_o,
	output logic halt_o
);
	localparam int WRITERS = MUL_STAGES + 3;

	rv_isa_pkg::rv_instr_u instr;
	logic uses_rs1;
	logic uses_rs2;
	logic is_mul;
	logic [WRITERS-1:0] wr_valid;
	logic [WRITERS-1:0][4:0] wr_rd;
	logic conflict;
	logic ecall_wait;
	logic dstall;
	logic go;
	logic halt_q;
	logic access_q;

	assign instr = id_reg_i.instr;

	always_comb begin
		decode_o = '0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		is_mul = 1'b0;
		decode_o.rd = instr.rtype.rd;
		case (instr.rtype.opcode)
		rv_isa_pkg::OPC_OP: begin
			uses_rs1 = 1'b1;
			uses_rs2 = 1'b1;
			is_mul = (instr.rtype.funct7 == rv_isa_pkg::FUNCT7_MULDIV);
			decode_o.regfile_we = !is_mul; // MUL writes through its own port.
			if (instr.rtype.funct7 == rv_isa_pkg::FUNCT7_SUB)
				decode_o.alu_op = core_pipe_pkg::ALU_SUB;
		end
		rv_isa_pkg::OPC_OP_IMM: begin
			uses_rs1 = 1'b1;
			decode_o.regfile_we = 1'b1;
			decode_o.use_imm = 1'b1;
		end
		rv_isa_pkg::OPC_LOAD: begin
			uses_rs1 = 1'b1;
			decode_o.regfile_we = 1'b1;
			decode_o.mem_read = 1'b1;
			decode_o.use_imm = 1'b1;
			decode_o.wb_sel = core_pipe_pkg::WB_LOAD;
		end
		rv_isa_pkg::OPC_STORE: begin
			uses_rs1 = 1'b1;
			uses_rs2 = 1'b1;
			decode_o.mem_write = 1'b1;
			decode_o.use_imm = 1'b1;
		end
		rv_isa_pkg::OPC_SYSTEM:
			decode_o.is_ecall = 1'b1;
		default: ;
		endcase
	end

	// Every in-flight writer, main pipe first and then the multiply slots.
	// A matching destination also blocks, so the two write ports never collide.
	always_comb begin
		wr_valid[0] = ex_reg_i.valid && ex_reg_i.regfile_we;
		wr_rd[0] = ex_reg_i.rd;
		wr_valid[1] = mem_reg_i.valid && mem_reg_i.regfile_we;
		wr_rd[1] = mem_reg_i.rd;
		wr_valid[2] = wb_reg_i.valid && wb_reg_i.regfile_we;
		wr_rd[2] = wb_reg_i.rd;
		for (int i = 0; i < MUL_STAGES; i++) begin
			wr_valid[i + 3] = mul_busy_i[i];
			wr_rd[i + 3] = mul_rd_i[i];
		end
		conflict = 1'b0;
		for (int i = 0; i < WRITERS; i++) begin
			if (wr_valid[i] && wr_rd[i] != 5'd0) begin
				if (uses_rs1 && wr_rd[i] == instr.rtype.rs1)
					conflict = 1'b1;
				if (uses_rs2 && wr_rd[i] == instr.rtype.rs2)
					conflict = 1'b1;
				if ((decode_o.regfile_we || is_mul) && wr_rd[i] == instr.rtype.rd)
					conflict = 1'b1;
			end
		end
	end

	assign ecall_wait = decode_o.is_ecall &&
		(ex_reg_i.valid || mem_reg_i.valid || wb_reg_i.valid || (|mul_busy_i));
	assign dstall = mem_reg_i.valid && (mem_reg_i.mem_read || mem_reg_i.mem_write) &&
		!dcache_hit_i;
	assign go = id_reg_i.valid && !conflict && !ecall_wait && !dstall;

	assign id_stall_o = id_reg_i.valid && !go;
	assign ex_stall_o = dstall;
	assign mem_stall_o = dstall;
	assign ex_valid_o = go && !is_mul; // A MUL leaves a bubble behind.
	assign mul_issue_o = go && is_mul;
	assign halt_o = halt_q || (go && decode_o.is_ecall);
	assign pc_stall_o = !icache_hit_i || id_stall_o || halt_o;
	assign icache_access_o = access_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			halt_q <= 1'b0;
			access_q <= 1'b0;
		end else begin
			halt_q <= halt_o;
			// After halt the open request is still finished before access drops.
			access_q <= halt_o ? (access_q && !icache_hit_i) : 1'b1;
		end
	end
endmodule

//--- hdl/mem_model.sv
module mem_model #(
	parameter int MEM_WORDS = 2048
) (
	input logic clk_i,
	input logic reset_i,
	cache_if.slave ibus,
	cache_if.slave dbus,
	input logic prog_we_i,
	input logic [10:0] prog_addr_i,
	input logic [31:0] prog_data_i
);
	localparam int AW = $clog2(MEM_WORDS);

	logic [31:0] mem [MEM_WORDS];
	logic [AW-1:0] iidx;
	logic [AW-1:0] didx;

	assign iidx = ibus.addr[AW+1:2];
	assign didx = dbus.addr[AW+1:2];

	// Hit follows one cycle after access and is never raised twice in a row.
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ibus.hit <= 1'b0;
			dbus.hit <= 1'b0;
		end else begin
			ibus.hit <= ibus.access && !ibus.hit;
			dbus.hit <= dbus.access && !dbus.hit;
		end
	end

	always_ff @(posedge clk_i) begin
		ibus.rd_data <= mem[iidx];
		dbus.rd_data <= mem[didx];
		if (prog_we_i)
			mem[AW'(prog_addr_i)] <= prog_data_i;
		if (ibus.hit && ibus.write)
			mem[iidx] <= ibus.wr_data;
		if (dbus.hit && dbus.write)
			mem[didx] <= dbus.wr_data; // Stores land on the hit edge.
	end
endmodule

//--- hdl/mul_stage.sv
module mul_stage #(
	parameter bit LAST = 1'b0
) (
	input logic clk_i,
	input logic reset_i,
	input core_pipe_pkg::mul_slot_t slot_i,
	output core_pipe_pkg::mul_slot_t slot_o
);
	always_ff @(posedge clk_i) begin
		slot_o <= slot_i;
		if (LAST)
			slot_o.product <= slot_i.op1 * slot_i.op2; // Low word only.
		if (reset_i)
			slot_o.valid <= 1'b0;
	end
endmodule

//--- hdl/regfile.sv
module regfile (
	input logic clk_i,
	input logic reset_i,
	input logic [4:0] rd_addr1_i,
	input logic [4:0] rd_addr2_i,
	input logic [4:0] dbg_addr_i,
	input logic [4:0] wr_addr_i,
	input logic [31:0] wr_data_i,
	input logic wr_en_i,
	input logic [4:0] mul_wr_addr_i,
	input logic [31:0] mul_wr_data_i,
	input logic mul_wr_en_i,
	output logic [31:0] rd_data1_o,
	output logic [31:0] rd_data2_o,
	output logic [31:0] dbg_data_o
);
	logic [31:0] regs [32];
	logic wr_ok;
	logic mul_ok;

	assign wr_ok = wr_en_i && (wr_addr_i != 5'd0); // x0 stays zero.
	assign mul_ok = mul_wr_en_i && (mul_wr_addr_i != 5'd0);

	// A write in this cycle is passed straight to the read ports.
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (mul_ok && mul_wr_addr_i == addr)
			return mul_wr_data_i;
		if (wr_ok && wr_addr_i == addr)
			return wr_data_i;
		return regs[addr];
	endfunction

	always_comb begin
		rd_data1_o = read_port(rd_addr1_i);
		rd_data2_o = read_port(rd_addr2_i);
	end

	assign dbg_data_o = regs[dbg_addr_i];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else begin
			if (wr_ok)
				regs[wr_addr_i] <= wr_data_i;
			if (mul_ok)
				regs[mul_wr_addr_i] <= mul_wr_data_i;
		end
	end
endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
	localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_rtype_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_itype_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} rv_stype_t;

	// Register fields come from the R view, immediates from the I or S view.
	typedef union packed {
		rv_rtype_t rtype;
		rv_itype_t itype;
		rv_stype_t stype;
	} rv_instr_u;
endpackage

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f flist.f --top-module tb_core -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_core)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

//--- tb/core_checker.sv
module core_checker (
	input logic clk_i,
	input logic reset_i,
	input logic halted_i,
	input logic [31:0] retired_i,
	input logic [31:0] dbg_data_i,
	input logic [31:0][31:0] exp_regs_i,
	input logic [31:0] exp_retired_i,
	input int test_id_i,
	output logic [4:0] dbg_addr_o,
	output int tests_done_o,
	output int checks_o,
	output int errors_o
);
	timeunit 1ns;
	timeprecision 1ps;

	int test_errors;

	task automatic compare(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checks_o++;
		if (got !== expected) begin
			errors_o++;
			test_errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	initial begin
		dbg_addr_o = '0;
		tests_done_o = 0;
		checks_o = 0;
		errors_o = 0;
		test_errors = 0;
		forever begin
			@(negedge reset_i);
			test_errors = 0;
			compare("halted_o after reset", {31'd0, halted_i}, 32'd0);
			compare("retired_o after reset", retired_i, 32'd0);
			while (halted_i !== 1'b1)
				@(negedge clk_i);
			@(negedge clk_i); // The ECALL is counted one edge after halted_o rises.
			compare("retired_o", retired_i, exp_retired_i);
			for (int r = 0; r < 32; r++) begin
				dbg_addr_o = 5'(r);
				@(negedge clk_i);
				compare($sformatf("register x%0d", r), dbg_data_i, exp_regs_i[r]);
			end
			compare("halted_o held", {31'd0, halted_i}, 32'd1);
			if (test_errors == 0)
				$display("test %0d ok, %0d instructions retired", test_id_i, retired_i);
			else
				$display("test %0d had %0d errors", test_id_i, test_errors);
			tests_done_o++;
		end
	end
endmodule

//--- tb/tb_core.sv
module tb_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MUL_STAGES = 4;
	localparam int DATA_WORDS = 16;
	localparam logic [10:0] PROG_BASE = 11'h400; // Word address of the reset PC.
	localparam logic [31:0] ECALL = {25'd0, rv_isa_pkg::OPC_SYSTEM};

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic prog_we = 1'b0;
	logic [10:0] prog_addr = '0;
	logic [31:0] prog_data = '0;
	logic [4:0] dbg_addr;
	logic [31:0] dbg_data;
	logic halted;
	logic [31:0] retired;

	logic [31:0] prog [64];
	int prog_len = 0;
	logic [31:0] data_init [DATA_WORDS];
	logic [31:0][31:0] exp_regs = '0;
	logic [31:0] exp_retired = '0;
	int test_id = 0;
	int tests_done;
	int checks;
	int errors;
	int seed = 20170;
	int run_cycles = 0;
	int cycle_limit = 0;

	always #10 clk = ~clk;

	core_top #(
		.MUL_STAGES(MUL_STAGES)
	) core_top_i (
		.clk_i(clk),
		.reset_i(reset),
		.prog_we_i(prog_we),
		.prog_addr_i(prog_addr),
		.prog_data_i(prog_data),
		.dbg_addr_i(dbg_addr),
		.dbg_data_o(dbg_data),
		.halted_o(halted),
		.retired_o(retired)
	);

	core_checker checker_i (
		.clk_i(clk),
		.reset_i(reset),
		.halted_i(halted),
		.retired_i(retired),
		.dbg_data_i(dbg_data),
		.exp_regs_i(exp_regs),
		.exp_retired_i(exp_retired),
		.test_id_i(test_id),
		.dbg_addr_o(dbg_addr),
		.tests_done_o(tests_done),
		.checks_o(checks),
		.errors_o(errors)
	);

	function automatic logic [31:0] addi_instr(input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), 3'b000, 5'(rd), rv_isa_pkg::OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] op_instr(input logic [6:0] funct7, input int rd,
		input int rs1, input int rs2);
		return {funct7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), rv_isa_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] lw_instr(input int rd, input int rs1, input int offset);
		return {12'(offset), 5'(rs1), 3'b010, 5'(rd), rv_isa_pkg::OPC_LOAD};
	endfunction

	function automatic logic [31:0] sw_instr(input int rs2, input int rs1, input int offset);
		logic [11:0] imm;
		imm = 12'(offset);
		return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_isa_pkg::OPC_STORE};
	endfunction

	function automatic void append(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endfunction

	function automatic int draw(input int n);
		int unsigned r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	// Plain ISA loop over the program, with the data words as its memory.
	function automatic int rv_model(output logic [31:0][31:0] regs);
		logic [31:0] mem [DATA_WORDS];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [4:0] rd;
		int count;
		regs = '0;
		count = 0;
		for (int i = 0; i < DATA_WORDS; i++)
			mem[i] = data_init[i];
		for (int pc = 0; pc < prog_len; pc++) begin
			w = prog[pc];
			rd = w[11:7];
			a = regs[w[19:15]];
			b = regs[w[24:20]];
			count++;
			if (w[6:0] == rv_isa_pkg::OPC_SYSTEM)
				break;
			case (w[6:0])
			rv_isa_pkg::OPC_OP_IMM:
				regs[rd] = a + {{20{w[31]}}, w[31:20]};
			rv_isa_pkg::OPC_OP:
				if (w[31:25] == rv_isa_pkg::FUNCT7_MULDIV)
					regs[rd] = a * b;
				else if (w[31:25] == rv_isa_pkg::FUNCT7_SUB)
					regs[rd] = a - b;
				else
					regs[rd] = a + b;
			rv_isa_pkg::OPC_LOAD: begin
				addr = a + {{20{w[31]}}, w[31:20]};
				regs[rd] = mem[addr[5:2]];
			end
			rv_isa_pkg::OPC_STORE: begin
				addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
				mem[addr[5:2]] = b;
			end
			default: ;
			endcase
			regs[0] = '0;
		end
		return count;
	endfunction

	function automatic void chain_program();
		prog_len = 0;
		append(addi_instr(1, 0, 5));
		append(addi_instr(2, 1, 7));
		append(op_instr(7'd0, 3, 1, 2));
		append(op_instr(rv_isa_pkg::FUNCT7_SUB, 4, 3, 1));
		append(op_instr(rv_isa_pkg::FUNCT7_SUB, 5, 0, 4));
		append(addi_instr(0, 0, 9)); // x0 must stay zero.
		append(op_instr(7'd0, 0, 3, 3));
		append(op_instr(7'd0, 6, 5, 0));
		append(addi_instr(1, 1, -100));
		append(op_instr(7'd0, 7, 1, 6));
		append(ECALL);
	endfunction

	function automatic void memory_program();
		prog_len = 0;
		append(lw_instr(1, 0, 0));
		append(lw_instr(2, 0, 12));
		append(addi_instr(3, 0, 'h123));
		append(sw_instr(3, 0, 8));
		append(lw_instr(4, 0, 8));
		append(lw_instr(5, 0, 4));
		append(addi_instr(6, 0, 16));
		append(sw_instr(1, 6, 8));
		append(lw_instr(7, 0, 24));
		append(lw_instr(8, 6, 20));
		append(op_instr(7'd0, 9, 7, 4));
		append(ECALL);
	endfunction

	function automatic void mul_program();
		prog_len = 0;
		append(addi_instr(1, 0, 13));
		append(addi_instr(2, 0, -7));
		append(op_instr(rv_isa_pkg::FUNCT7_MULDIV, 3, 1, 2));
		append(op_instr(rv_isa_pkg::FUNCT7_MULDIV, 4, 3, 3));
		append(op_instr(rv_isa_pkg::FUNCT7_MULDIV, 5, 1, 1));
		append(op_instr(7'd0, 6, 3, 5));
		append(op_instr(rv_isa_pkg::FUNCT7_MULDIV, 3, 2, 2)); // x3 reused at once.
		append(addi_instr(3, 3, 1));
		append(op_instr(rv_isa_pkg::FUNCT7_SUB, 7, 4, 3));
		append(lw_instr(8, 0, 0));
		append(op_instr(rv_isa_pkg::FUNCT7_MULDIV, 9, 8, 8));
		append(ECALL);
	endfunction

	function automatic void random_program();
		int kind;
		int rd;
		int rs1;
		int rs2;
		int offset;
		prog_len = 0;
		for (int i = 0; i < 24; i++) begin
			kind = draw(6);
			rd = draw(8);
			rs1 = draw(8);
			rs2 = draw(8);
			offset = 4 * draw(DATA_WORDS);
			case (kind)
			0: append(addi_instr(rd, rs1, draw(4096) - 2048));
			1: append(op_instr(7'd0, rd, rs1, rs2));
			2: append(op_instr(rv_isa_pkg::FUNCT7_SUB, rd, rs1, rs2));
			3: append(op_instr(rv_isa_pkg::FUNCT7_MULDIV, rd, rs1, rs2));
			4: append(lw_instr(rd, 0, offset));
			default: append(sw_instr(rs2, 0, offset));
			endcase
		end
		append(ECALL);
	endfunction

	task automatic load_word(input logic [10:0] addr, input logic [31:0] word);
		prog_we = 1'b1;
		prog_addr = addr;
		prog_data = word;
		@(negedge clk);
	endtask

	task automatic run_program();
		int target;
		exp_retired = 32'(rv_model(exp_regs));
		cycle_limit += prog_len * (MUL_STAGES + 8) + 20;
		test_id++;
		target = tests_done + 1;
		@(negedge clk);
		reset = 1'b1;
		repeat (10) @(negedge clk);
		for (int i = 0; i < DATA_WORDS; i++)
			load_word(11'(i), data_init[i]);
		for (int i = 0; i < prog_len; i++)
			load_word(PROG_BASE + 11'(i), prog[i]);
		prog_we = 1'b0;
		reset = 1'b0;
		while (tests_done != target)
			@(negedge clk);
	endtask

	// Only cycles in which the core runs count against the limit.
	always @(negedge clk) begin
		if (!reset && halted !== 1'b1)
			run_cycles++;
		if (run_cycles > cycle_limit) begin
			$display("Timeout: the core did not halt within %0d cycles.", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		for (int i = 0; i < DATA_WORDS; i++)
			data_init[i] = 32'hd00d_0000 ^ (32'(i) * 32'h0102_0305);
		chain_program();
		run_program();
		memory_program();
		run_program();
		mul_program();
		run_program();
		random_program();
		run_program();
		$display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end
endmodule
